/* source/jp2k_pkg.sv */
package jp2k_pkg;

    // tile geometry and memory addressing.
    localparam int TILE_PAIRS = 8;
    localparam int ADDR_W     = 18;
    localparam int PAIR_IDX_W = 3;

    // data path widths.
    localparam int SAMPLE_W = 16;
    localparam int WORD_W   = 32;
    localparam int WAV_W    = 18;   // 5/3 coefficients need two bits over the sample width.
    localparam int MAG_W    = 16;
    localparam int COEF_W   = 17;
    localparam int RATIO_W  = 3;
    localparam int PLANE_W  = 5;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // even sample in the high half and odd sample in the low half.
    typedef logic [WORD_W-1:0] word_t;

    typedef logic [ADDR_W-1:0] addr_t;

    typedef logic signed [WAV_W-1:0] wavelet_t;

    typedef logic [MAG_W-1:0] mag_t;

    // sign in the top bit, magnitude below it.
    typedef logic [COEF_W-1:0] coef_t;

    typedef logic [RATIO_W-1:0] ratio_t;

    typedef logic [PLANE_W-1:0] plane_count_t;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        DRAIN
    } tile_state_t;

endpackage

/* source/sample_if.sv */
`timescale 1ns/1ps

interface sample_if
    import jp2k_pkg::*;
();

    sample_t even;
    sample_t odd;
    logic    vld;   // one pair per cycle while high.
    logic    last;  // marks the final pair of the tile.

    modport src (
        output even, odd, vld, last
    );

    modport dst (
        input even, odd, vld, last
    );

endinterface

/* source/coef_if.sv */
`timescale 1ns/1ps

interface coef_if
    import jp2k_pkg::*;
();

    // on the quantized bus the coef_t value sits in the low bits.
    wavelet_t low;
    wavelet_t high;
    logic     vld;
    logic     last;

    modport src (
        output low, high, vld, last
    );

    modport dst (
        input low, high, vld, last
    );

endinterface

/* source/tile_ctrl.sv */
`timescale 1ns/1ps

module tile_ctrl
    import jp2k_pkg::*;
(
    input  logic  clk_dwt,
    input  logic  rst,
    input  logic  start_cpu,
    input  word_t douta_all_1,
    input  logic  one_codeblock_over,
    output addr_t addra_all_1,
    output logic  start_dwt,
    sample_if.src samples
);

    tile_state_t           state;
    logic [PAIR_IDX_W-1:0] pair_cnt;
    addr_t                 tile_base;
    logic                  fetch_last;
    logic                  rd_vld;
    logic                  rd_last;

    assign fetch_last = (pair_cnt == PAIR_IDX_W'(TILE_PAIRS - 1));

    // pair_cnt wraps back to zero after the last fetch so the address rests on tile_base.
    assign addra_all_1 = tile_base + addr_t'(pair_cnt);

    assign start_dwt = (state != IDLE);

    always_ff @(posedge clk_dwt or negedge rst)
    begin
        if (!rst)
        begin
            state     <= IDLE;
            pair_cnt  <= '0;
            tile_base <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (start_cpu)
                    begin
                        state    <= FETCH;
                        pair_cnt <= '0;
                    end
                end
                FETCH:
                begin
                    pair_cnt <= pair_cnt + 1'b1;
                    if (fetch_last)
                    begin
                        state     <= DRAIN;
                        tile_base <= tile_base + addr_t'(TILE_PAIRS);  // next tile block.
                    end
                end
                DRAIN:
                begin
                    if (one_codeblock_over)
                        state <= IDLE;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    // the memory answers one cycle after the address, so the strobes follow it.
    always_ff @(posedge clk_dwt or negedge rst)
    begin
        if (!rst)
        begin
            rd_vld       <= 1'b0;
            rd_last      <= 1'b0;
            samples.vld  <= 1'b0;
            samples.last <= 1'b0;
        end
        else
        begin
            rd_vld       <= (state == FETCH);
            rd_last      <= (state == FETCH) && fetch_last;
            samples.vld  <= rd_vld;
            samples.last <= rd_last;
        end
    end

    always_ff @(posedge clk_dwt)
    begin
        if (rd_vld)
        begin
            samples.even <= douta_all_1[WORD_W-1:SAMPLE_W];
            samples.odd  <= douta_all_1[SAMPLE_W-1:0];
        end
    end

endmodule

/* source/dwt_lifting.sv */
`timescale 1ns/1ps

module dwt_lifting
    import jp2k_pkg::*;
(
    input  logic  clk_dwt,
    input  logic  rst,
    sample_if.dst samples,
    coef_if.src   wav_bus
);

    sample_t                 e_p;       // held pair n.
    sample_t                 o_p;
    wavelet_t                d_prev;    // highpass of pair n-1.
    logic                    hold;
    logic                    first;
    logic                    flush;
    logic                    step;
    sample_t                 e_next;
    logic signed [SAMPLE_W:0] pred_sum;
    wavelet_t                d_new;
    wavelet_t                d_left;
    logic signed [WAV_W:0]   upd_sum;
    logic signed [WAV_W:0]   s_full;

    // a pair is finished when its right neighbour arrives or in the flush cycle.
    assign step = (samples.vld && hold) || flush;

    always_comb
    begin
        e_next   = flush ? e_p : samples.even;  // mirror even(N-1) past the tile end.
        pred_sum = e_p + e_next;
        d_new    = o_p - (pred_sum >>> 1);
        d_left   = first ? d_new : d_prev;      // pair 0 reuses d(0) as d(-1).
        upd_sum  = d_left + d_new + 2;
        s_full   = e_p + (upd_sum >>> 2);
    end

    always_ff @(posedge clk_dwt or negedge rst)
    begin
        if (!rst)
        begin
            hold         <= 1'b0;
            first        <= 1'b0;
            flush        <= 1'b0;
            wav_bus.vld  <= 1'b0;
            wav_bus.last <= 1'b0;
        end
        else
        begin
            flush        <= samples.vld && samples.last;
            wav_bus.vld  <= step;
            wav_bus.last <= flush;
            if (samples.vld)
            begin
                hold  <= 1'b1;
                first <= !hold;  // nothing held means this is pair 0.
            end
            else if (flush)
            begin
                hold <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_dwt)
    begin
        if (samples.vld)
        begin
            e_p <= samples.even;
            o_p <= samples.odd;
        end
        if (step)
        begin
            d_prev       <= d_new;
            wav_bus.low  <= s_full[WAV_W-1:0];
            wav_bus.high <= d_new;
        end
    end

endmodule

/* source/coef_quantizer.sv */
`timescale 1ns/1ps

module coef_quantizer
    import jp2k_pkg::*;
(
    input  logic   clk_dwt,
    input  logic   rst,
    input  ratio_t compression_ratio,
    coef_if.dst    wav_bus,
    coef_if.src    quant_bus
);

    // sign-magnitude with the magnitude shifted down by the ratio.
    function automatic coef_t quantize(wavelet_t c, ratio_t r);
        wavelet_t abs_c;
        mag_t     shifted;
        abs_c   = c[WAV_W-1] ? -c : c;
        shifted = abs_c[MAG_W-1:0] >> r;
        return {c[WAV_W-1] && (shifted != '0), shifted};  // no negative zero.
    endfunction

    always_ff @(posedge clk_dwt or negedge rst)
    begin
        if (!rst)
        begin
            quant_bus.vld  <= 1'b0;
            quant_bus.last <= 1'b0;
        end
        else
        begin
            quant_bus.vld  <= wav_bus.vld;
            quant_bus.last <= wav_bus.vld && wav_bus.last;
        end
    end

    always_ff @(posedge clk_dwt)
    begin
        if (wav_bus.vld)
        begin
            quant_bus.low  <= {{(WAV_W-COEF_W){1'b0}}, quantize(wav_bus.low, compression_ratio)};
            quant_bus.high <= {{(WAV_W-COEF_W){1'b0}}, quantize(wav_bus.high, compression_ratio)};
        end
    end

endmodule

/* source/bitplane_scan.sv */
`timescale 1ns/1ps

module bitplane_scan
    import jp2k_pkg::*;
(
    input  logic         clk_dwt,
    input  logic         rst,
    coef_if.dst          quant_bus,
    output plane_count_t zero_plane_low,
    output plane_count_t zero_plane_high,
    output logic         one_codeblock_over
);

    mag_t acc_low;
    mag_t acc_high;
    mag_t mag_low;
    mag_t mag_high;

    function automatic plane_count_t lead_zeros(mag_t v);
        plane_count_t n;
        logic         found;
        n     = plane_count_t'(MAG_W);
        found = 1'b0;
        for (int i = MAG_W - 1; i >= 0; i--)
        begin
            if (!found && v[i])
            begin
                n     = plane_count_t'(MAG_W - 1 - i);
                found = 1'b1;
            end
        end
        return n;
    endfunction

    // magnitude bits sit below the sign of the coef_t value.
    assign mag_low  = quant_bus.low[MAG_W-1:0];
    assign mag_high = quant_bus.high[MAG_W-1:0];

    always_ff @(posedge clk_dwt or negedge rst)
    begin
        if (!rst)
        begin
            acc_low            <= '0;
            acc_high           <= '0;
            zero_plane_low     <= plane_count_t'(MAG_W);
            zero_plane_high    <= plane_count_t'(MAG_W);
            one_codeblock_over <= 1'b0;
        end
        else
        begin
            one_codeblock_over <= quant_bus.vld && quant_bus.last;
            if (quant_bus.vld && quant_bus.last)
            begin
                zero_plane_low  <= lead_zeros(acc_low | mag_low);
                zero_plane_high <= lead_zeros(acc_high | mag_high);
                acc_low         <= '0;  // ready for the next tile.
                acc_high        <= '0;
            end
            else if (quant_bus.vld)
            begin
                acc_low  <= acc_low | mag_low;
                acc_high <= acc_high | mag_high;
            end
        end
    end

endmodule

/* source/jp2k_dwt_top.sv */
`timescale 1ns/1ps

module jp2k_dwt_top
    import jp2k_pkg::*;
(
    input  logic         clk_dwt,
    input  logic         rst,
    input  logic         start_cpu,
    input  ratio_t       compression_ratio,
    input  word_t        douta_all_1,
    output addr_t        addra_all_1,
    output logic         start_dwt,
    output coef_t        coef_low,
    output coef_t        coef_high,
    output logic         coef_vld,
    output logic         coef_last,
    output plane_count_t zero_plane_low,
    output plane_count_t zero_plane_high,
    output logic         one_codeblock_over
);

    sample_if samples();
    coef_if   wav_bus();
    coef_if   quant_bus();

    tile_ctrl u_tile_ctrl (
        .clk_dwt            (clk_dwt),
        .rst                (rst),
        .start_cpu          (start_cpu),
        .douta_all_1        (douta_all_1),
        .one_codeblock_over (one_codeblock_over),
        .addra_all_1        (addra_all_1),
        .start_dwt          (start_dwt),
        .samples            (samples)
    );

    dwt_lifting u_dwt_lifting (
        .clk_dwt (clk_dwt),
        .rst     (rst),
        .samples (samples),
        .wav_bus (wav_bus)
    );

    coef_quantizer u_coef_quantizer (
        .clk_dwt           (clk_dwt),
        .rst               (rst),
        .compression_ratio (compression_ratio),
        .wav_bus           (wav_bus),
        .quant_bus         (quant_bus)
    );

    bitplane_scan u_bitplane_scan (
        .clk_dwt            (clk_dwt),
        .rst                (rst),
        .quant_bus          (quant_bus),
        .zero_plane_low     (zero_plane_low),
        .zero_plane_high    (zero_plane_high),
        .one_codeblock_over (one_codeblock_over)
    );

    // quantized coefficients leave the chip without any handshake.
    assign coef_low  = quant_bus.low[COEF_W-1:0];
    assign coef_high = quant_bus.high[COEF_W-1:0];
    assign coef_vld  = quant_bus.vld;
    assign coef_last = quant_bus.last;

endmodule

/* tb/jp2k_dwt_tb.sv */
`timescale 1ns/1ps

module jp2k_dwt_tb
    import jp2k_pkg::*;
();

    localparam int CLK_PERIOD      = 40;
    localparam int NUM_FILE_CASES  = 11;
    localparam int NUM_RAND_CASES  = 6;
    localparam int NUM_CASES       = NUM_FILE_CASES + NUM_RAND_CASES;
    localparam int CASE_COLS       = TILE_PAIRS + 3;  // ratio, the words and two plane counts.
    localparam int MEM_DEPTH       = NUM_CASES * TILE_PAIRS;
    localparam int WATCHDOG_CYCLES = NUM_CASES * (TILE_PAIRS + 10) + 100;

    logic         clk_dwt = 1'b0;
    logic         rst;
    logic         start_cpu;
    ratio_t       compression_ratio;
    word_t        douta_all_1;
    addr_t        addra_all_1;
    logic         start_dwt;
    coef_t        coef_low;
    coef_t        coef_high;
    logic         coef_vld;
    logic         coef_last;
    plane_count_t zero_plane_low;
    plane_count_t zero_plane_high;
    logic         one_codeblock_over;

    logic [31:0]  case_mem [NUM_FILE_CASES*CASE_COLS];
    word_t        mem [MEM_DEPTH];
    ratio_t       case_ratio [NUM_CASES];
    plane_count_t exp_zl [NUM_CASES];
    plane_count_t exp_zh [NUM_CASES];
    coef_t        low_q [$];
    coef_t        high_q [$];
    integer       seed;
    int           tile_num = 0;
    int           beat_cnt = 0;
    int           fetch_cnt = 0;
    logic         exp_busy = 1'b0;
    logic         prev_busy = 1'b0;

    jp2k_dwt_top UUT (
        .clk_dwt            (clk_dwt),
        .rst                (rst),
        .start_cpu          (start_cpu),
        .compression_ratio  (compression_ratio),
        .douta_all_1        (douta_all_1),
        .addra_all_1        (addra_all_1),
        .start_dwt          (start_dwt),
        .coef_low           (coef_low),
        .coef_high          (coef_high),
        .coef_vld           (coef_vld),
        .coef_last          (coef_last),
        .zero_plane_low     (zero_plane_low),
        .zero_plane_high    (zero_plane_high),
        .one_codeblock_over (one_codeblock_over)
    );

    always #(CLK_PERIOD/2) clk_dwt = ~clk_dwt;

    task automatic stop_run();
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0d ns: %s", $time, what);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("FAILED at %0d ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            stop_run();
        end
    endtask

    function automatic int floor_div(int num, int den);
        int q;
        q = num / den;
        if ((num % den != 0) && (num < 0))
            q = q - 1;  // integer division truncates but the lifting rules round down.
        return q;
    endfunction

    function automatic coef_t quant_model(int c, int r);
        int m;
        m = (c < 0) ? -c : c;
        m = m >> r;
        return {(c < 0) && (m != 0), m[15:0]};
    endfunction

    function automatic plane_count_t zero_planes(logic [15:0] v);
        plane_count_t n;
        n = 5'd16;
        while (v != 16'd0)
        begin
            v = v >> 1;
            n = n - 5'd1;
        end
        return n;
    endfunction

    function automatic int sample_at(word_t w, logic hi);
        sample_t s;
        s = hi ? w[31:16] : w[15:0];
        return int'(s);
    endfunction

    function automatic word_t make_word(logic [31:0] w, int sh);
        sample_t e;
        sample_t o;
        e = w[31:16];
        o = w[15:0];
        e = e >>> sh;
        o = o >>> sh;
        return {e, o};
    endfunction

    // addresses past the loaded tiles still return a word tied to the address.
    function automatic word_t fill_word(addr_t a);
        return 32'h5a5a_0000 ^ word_t'(a);
    endfunction

    task automatic load_cases();
        int base;
        $readmemh("tb/dwt_cases.txt", case_mem);
        for (int k = 0; k < NUM_FILE_CASES; k++)
        begin
            base = k * CASE_COLS;
            if (case_mem[base] > 7 || case_mem[base + TILE_PAIRS + 1] > 16 ||
                case_mem[base + TILE_PAIRS + 2] > 16)
                report_error("the cases file holds a ratio or plane count out of range");
            case_ratio[k] = ratio_t'(case_mem[base]);
            for (int n = 0; n < TILE_PAIRS; n++)
                mem[k*TILE_PAIRS + n] = case_mem[base + 1 + n];
            exp_zl[k] = plane_count_t'(case_mem[base + TILE_PAIRS + 1]);
            exp_zh[k] = plane_count_t'(case_mem[base + TILE_PAIRS + 2]);
        end
    endtask

    task automatic make_random_cases();
        logic [31:0] w;
        seed = 32'hf4755b8d;
        for (int k = NUM_FILE_CASES; k < NUM_CASES; k++)
        begin
            w             = $random(seed);
            case_ratio[k] = ratio_t'(w[2:0]);
            for (int n = 0; n < TILE_PAIRS; n++)
            begin
                w = $random(seed);
                // later tiles are quieter.
                mem[k*TILE_PAIRS + n] = make_word(w, 2 * (k - NUM_FILE_CASES));
            end
        end
    endtask

    task automatic build_expected(input int k);
        int          ev [TILE_PAIRS];
        int          od [TILE_PAIRS];
        int          d [TILE_PAIRS];
        int          e_right;
        int          d_left;
        int          s;
        coef_t       ql;
        coef_t       qh;
        logic [15:0] or_low;
        logic [15:0] or_high;
        or_low  = '0;
        or_high = '0;
        for (int n = 0; n < TILE_PAIRS; n++)
        begin
            ev[n] = sample_at(mem[k*TILE_PAIRS + n], 1'b1);
            od[n] = sample_at(mem[k*TILE_PAIRS + n], 1'b0);
        end
        for (int n = 0; n < TILE_PAIRS; n++)
        begin
            e_right = (n == TILE_PAIRS - 1) ? ev[n] : ev[n + 1];  // mirrored past the tile end.
            d[n]    = od[n] - floor_div(ev[n] + e_right, 2);
        end
        for (int n = 0; n < TILE_PAIRS; n++)
        begin
            d_left  = (n == 0) ? d[0] : d[n - 1];
            s       = ev[n] + floor_div(d_left + d[n] + 2, 4);
            ql      = quant_model(s, case_ratio[k]);
            qh      = quant_model(d[n], case_ratio[k]);
            or_low  = or_low | ql[15:0];
            or_high = or_high | qh[15:0];
            low_q.push_back(ql);
            high_q.push_back(qh);
        end
        if (k >= NUM_FILE_CASES)
        begin
            exp_zl[k] = zero_planes(or_low);
            exp_zh[k] = zero_planes(or_high);
        end
    endtask

    // sample memory with one cycle of read latency.
    always @(posedge clk_dwt)
    begin
        if (addra_all_1 < addr_t'(MEM_DEPTH))
            douta_all_1 <= mem[addra_all_1];
        else
            douta_all_1 <= fill_word(addra_all_1);
    end

    // a tile is in work from the edge that takes start_cpu in idle until the end pulse.
    always @(posedge clk_dwt)
    begin
        if (!rst)
            exp_busy <= 1'b0;
        else if (!exp_busy && start_cpu)
            exp_busy <= 1'b1;
        else if (exp_busy && one_codeblock_over)
            exp_busy <= 1'b0;
    end

    always @(negedge clk_dwt)
    begin
        if (rst)
        begin
            check_value("start_dwt", start_dwt, exp_busy);
            if (exp_busy && !prev_busy)
                fetch_cnt = 0;
            if (exp_busy && fetch_cnt < TILE_PAIRS)
            begin
                check_value("addra_all_1", addra_all_1, tile_num * TILE_PAIRS + fetch_cnt);
                fetch_cnt = fetch_cnt + 1;
            end
            prev_busy = exp_busy;
            if (coef_vld)
            begin
                if (low_q.size() == 0)
                    report_error("a coefficient strobe came with no coefficient expected");
                check_value("coef_low", coef_low, low_q.pop_front());
                check_value("coef_high", coef_high, high_q.pop_front());
                check_value("coef_last", coef_last, beat_cnt == TILE_PAIRS - 1);
                beat_cnt = beat_cnt + 1;
            end
            else
            begin
                check_value("coef_last", coef_last, 0);
            end
            if (one_codeblock_over)
            begin
                if (tile_num >= NUM_CASES)
                    report_error("a tile ended although no tile was started");
                check_value("coefficient beats per tile", beat_cnt, TILE_PAIRS);
                check_value("zero_plane_low", zero_plane_low, exp_zl[tile_num]);
                check_value("zero_plane_high", zero_plane_high, exp_zh[tile_num]);
                beat_cnt = 0;
                tile_num = tile_num + 1;
            end
        end
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the tiles did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        stop_run();
    end

    initial
    begin
        rst               = 1'b0;
        start_cpu         = 1'b0;
        compression_ratio = '0;
        douta_all_1       = '0;
        load_cases();
        make_random_cases();
        repeat (16) @(posedge clk_dwt);
        rst <= 1'b1;
        @(negedge clk_dwt);
        check_value("start_dwt", start_dwt, 0);
        check_value("coef_vld", coef_vld, 0);
        check_value("coef_last", coef_last, 0);
        check_value("one_codeblock_over", one_codeblock_over, 0);
        check_value("zero_plane_low", zero_plane_low, 16);
        check_value("zero_plane_high", zero_plane_high, 16);
        @(posedge clk_dwt);
        for (int k = 0; k < NUM_CASES; k++)
        begin
            build_expected(k);
            start_cpu         <= 1'b1;
            compression_ratio <= case_ratio[k];
            @(posedge clk_dwt);
            start_cpu <= 1'b0;
            repeat (3) @(posedge clk_dwt);
            start_cpu <= 1'b1;  // a second start in the middle of a tile.
            @(posedge clk_dwt);
            start_cpu <= 1'b0;
            while (tile_num <= k)
                @(posedge clk_dwt);
        end
        repeat (4) @(posedge clk_dwt);
        $display("All checks passed");
        $finish;
    end

endmodule

/* sources.f */
source/jp2k_pkg.sv
source/sample_if.sv
source/coef_if.sv
source/tile_ctrl.sv
source/dwt_lifting.sv
source/coef_quantizer.sv
source/bitplane_scan.sv
source/jp2k_dwt_top.sv
tb/jp2k_dwt_tb.sv

/* Makefile */
# Verilator build and run for the wavelet front end testbench.

VERILATOR ?= verilator
TOP       ?= jp2k_dwt_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0 --Wno-fatal
PASS_MSG  ?= All checks passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation log decides pass or fail.
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/dwt_cases.txt */
// columns: ratio, eight sample words (even sample in the high half), then the expected
// leading zero bit-planes of the lowpass band and of the highpass band, all in hex.
0 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 10 10
0 00640064 00640064 00640064 00640064 00640064 00640064 00640064 00640064 09 10
1 ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff 10 10
0 00000100 00000000 00000000 00000000 00000000 00000000 00000000 00000000 08 07
2 00000100 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0a 09
0 00000001 00020003 00040005 00060007 00080009 000a000b 000c000d 000e000f 0c 0f
0 7fff8000 7fff8000 7fff8000 7fff8000 7fff8000 7fff8000 7fff8000 7fff8000 10 00
3 03e80000 03e80000 03e80000 03e80000 03e80000 03e80000 03e80000 03e80000 0a 09
0 00000000 00000000 00000000 00000000 02000200 02000200 02000200 02000200 06 07
5 00000000 00000000 00000000 00000000 02000200 02000200 02000200 02000200 0b 0c
7 00000000 00000000 00000000 00007fff 00000000 00000000 00000000 00000000 09 08
